/* Makefile */
SIM = obj_dir/chan_emu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module chan_emu_tb -o chan_emu_sim

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/chan_emu_tb.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module chan_emu_tb;

    localparam int NS   = `NUM_SLICES;
    localparam int HIST = `HIST_SYMS;
    localparam int TAPS = `NUM_TAPS;

    logic                          emu_clk;
    logic                          emu_rst;
    logic                          run_i;
    logic [`RX_SYMS*`SYM_BITS-1:0] rx_bits_i;
    logic [`PI_WIDTH-1:0]          pi_code_i;
    logic                          coef_we_i;
    logic [3:0]                    coef_addr_i;
    logic signed [`COEF_WIDTH-1:0] coef_data_i;
    logic                          rx_take_o;
    logic [NS-1:0]                 adc_sign_o;
    logic [NS*`MAG_WIDTH-1:0]      adc_mag_o;
    logic                          adc_valid_o;
    logic                          clk_adc_o;

    integer seed = 32'hce11;
    int     errors = 0;
    int     checked = 0;
    int     sat_hits = 0;
    string  test_name = "reset";

    // reference model
    int         m_coef [TAPS] = '{default: 0};
    logic [1:0] m_hist [HIST] = '{default: 2'b00};   // index 0 is the oldest
    int         m_pi_last = 0;
    int         m_slip = 0;          // 0 none, 1 early, 2 late
    int         exp_sign [$];        // NS entries per frame
    int         exp_mag [$];
    int         pi_seq [7] = '{50, 127, 0, 60, 0, 127, 90};

    int cyc = 0;
    int last_valid = -1;
    int low_cnt = 0;

    tb_clkgen u_clkgen (.emu_clk(emu_clk), .emu_rst(emu_rst));

    chan_emu_top UUT (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .run_i       (run_i),
        .rx_bits_i   (rx_bits_i),
        .pi_code_i   (pi_code_i),
        .coef_we_i   (coef_we_i),
        .coef_addr_i (coef_addr_i),
        .coef_data_i (coef_data_i),
        .rx_take_o   (rx_take_o),
        .adc_sign_o  (adc_sign_o),
        .adc_mag_o   (adc_mag_o),
        .adc_valid_o (adc_valid_o),
        .clk_adc_o   (clk_adc_o)
    );

    function automatic int level(input logic [1:0] s);
        case (s)
            2'b00:   return -3;
            2'b01:   return -1;
            2'b10:   return 1;
            default: return 3;
        endcase
    endfunction

    task automatic finish_run();
        $display("errors: %0d, result sets checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        errors++;
        finish_run();
    endtask

    // slice k convolves tap t with history symbol t+k
    task automatic push_expected();
        int sum;
        for (int k = 0; k < NS; k++) begin
            sum = 0;
            for (int t = 0; t < TAPS; t++) begin
                sum += m_coef[t] * level(m_hist[t + k]);
            end
            exp_sign.push_back(sum >= 0);
            sum = (sum < 0) ? -sum : sum;
            exp_mag.push_back((sum > 255) ? 255 : sum);
        end
    endtask

    task automatic model_load();
        logic [1:0] nxt [HIST];
        int         n_new;
        n_new = (m_slip == 1) ? `CHUNK_WIDTH + 1 : (m_slip == 2) ? `CHUNK_WIDTH - 1 : `CHUNK_WIDTH;
        for (int i = 0; i < HIST; i++) begin
            if (i < HIST - n_new) begin
                nxt[i] = m_hist[i + n_new];
            end else begin
                nxt[i] = rx_bits_i[(i - HIST + n_new)*2 +: 2];
            end
        end
        m_hist = nxt;
        if (m_pi_last == `PI_MAX && pi_code_i == 0) begin
            m_slip = 1;
        end else if (m_pi_last == 0 && pi_code_i == `PI_MAX) begin
            m_slip = 2;
        end else begin
            m_slip = 0;
        end
        m_pi_last = pi_code_i;
    endtask

    // mode 0 random, 1 every tap = value, 2 only tap j = value
    task automatic write_table(input int mode, input int j, input int value);
        int c;
        for (int t = 0; t < TAPS; t++) begin
            case (mode)
                0:       c = ($random(seed) & 255) - 128;
                1:       c = value;
                default: c = (t == j) ? value : 0;
            endcase
            m_coef[t]   = c;
            coef_we_i   = 1'b1;
            coef_addr_i = 4'(t);
            coef_data_i = 8'(c);
            @(posedge emu_clk);
            #1;
        end
        coef_we_i = 1'b0;
    endtask

    task automatic present_frame(input int sym_mode, input int pi_mode, input int f);
        case (sym_mode)
            0:       rx_bits_i = 10'($random(seed));
            1:       rx_bits_i = '1;
            default: rx_bits_i = '0;
        endcase
        case (pi_mode)
            0:       pi_code_i = 7'($random(seed));
            1:       pi_code_i = 7'(1 + $unsigned($random(seed)) % (`PI_MAX - 1));   // no wrap
            default: pi_code_i = 7'(pi_seq[f % 7]);
        endcase
    endtask

    task automatic run_frames(input int n_frames, input int sym_mode, input int pi_mode);
        int loads;
        int waited;
        loads = 0;
        present_frame(sym_mode, pi_mode, 0);
        run_i = 1'b1;
        push_expected();                 // first pulse comes from the current history
        while (loads < n_frames) begin
            waited = 0;
            @(negedge emu_clk);
            while (!rx_take_o) begin
                waited++;
                if (waited > 12) begin
                    give_up("rx_take_o");
                end
                @(negedge emu_clk);
            end
            model_load();
            push_expected();
            loads++;
            @(posedge emu_clk);
            #1;
            if (loads < n_frames) begin
                present_frame(sym_mode, pi_mode, loads);
            end else begin
                run_i = 1'b0;
            end
        end
        repeat (3) @(posedge emu_clk);
        #1;
        // the set for the last loaded history never runs
        if (exp_sign.size() != NS) begin
            $display("FAIL %s pending results: expected %0d, actual %0d",
                     test_name, NS, exp_sign.size());
            errors++;
        end
        exp_sign.delete();
        exp_mag.delete();
    endtask

    task automatic compare_results();
        int es;
        int em;
        if (exp_sign.size() < NS) begin
            $display("adc_valid_o pulsed in test %s with no result expected", test_name);
            errors++;
        end else begin
            for (int k = 0; k < NS; k++) begin
                es = exp_sign.pop_front();
                em = exp_mag.pop_front();
                if (adc_sign_o[k] !== es[0] || adc_mag_o[k*8 +: 8] !== em[7:0]) begin
                    $display("FAIL %s slice %0d: expected sign %0d mag %0d, actual sign %b mag %0d",
                             test_name, k, es, em, adc_sign_o[k], adc_mag_o[k*8 +: 8]);
                    errors++;
                end
                if (adc_mag_o[k*8 +: 8] == 8'd255) begin
                    sat_hits++;
                end
            end
            checked++;
        end
    endtask

    // results and frame timing, sampled mid-cycle
    always @(negedge emu_clk) begin
        if (!emu_rst) begin
            cyc++;
            if (!clk_adc_o) begin
                low_cnt++;
            end
            if (rx_take_o && last_valid >= 0 && cyc - last_valid != 5) begin
                $display("FAIL %s rx_take_o after valid: expected 5, actual %0d",
                         test_name, cyc - last_valid);
                errors++;
            end
            if (adc_valid_o) begin
                compare_results();
                if (last_valid >= 0 && (cyc - last_valid != 6 || low_cnt != 3)) begin
                    $display("FAIL %s frame: expected 6 cycles 3 low, actual %0d cycles %0d low",
                             test_name, cyc - last_valid, low_cnt);
                    errors++;
                end
                last_valid = cyc;
                low_cnt    = 0;
            end
            if (!run_i) begin
                last_valid = -1;   // interval restarts with the next run
                low_cnt    = 0;
            end
        end
    end

    initial begin
        int waited;
        int j;
        int v;
        run_i       = 1'b0;
        rx_bits_i   = '0;
        pi_code_i   = '0;
        coef_we_i   = 1'b0;
        coef_addr_i = '0;
        coef_data_i = '0;
        waited      = 0;
        @(posedge emu_clk);
        while (emu_rst) begin
            waited++;
            if (waited > 40) begin
                give_up("reset release");
            end
            @(posedge emu_clk);
        end
        @(negedge emu_clk);
        if (adc_valid_o !== 1'b0 || rx_take_o !== 1'b0 || clk_adc_o !== 1'b1) begin
            $display("FAIL reset outputs: expected valid 0 take 0 clk 1, actual %b %b %b",
                     adc_valid_o, rx_take_o, clk_adc_o);
            errors++;
        end
        @(posedge emu_clk);
        #1;

        test_name = "zero_table";
        run_frames(6, 0, 1);

        test_name = "single_tap";
        repeat (3) begin
            j = $unsigned($random(seed)) % TAPS;
            v = 1 + $unsigned($random(seed)) % 127;
            if ($random(seed) & 1) begin
                v = -v;
            end
            write_table(2, j, v);
            run_frames(6, 0, 1);
        end

        test_name = "random_table";
        write_table(0, 0, 0);
        run_frames(20, 0, 0);

        test_name = "saturation";
        write_table(1, 0, 120);
        sat_hits = 0;
        run_frames(6, 1, 1);   // history fills with +3
        run_frames(6, 2, 1);   // then with -3
        if (sat_hits == 0) begin
            $display("no saturated magnitude was seen in test %s", test_name);
            errors++;
        end

        test_name = "pi_slip";
        write_table(0, 0, 0);
        run_frames(14, 0, 2);

        if (checked == 0) begin
            $display("no result set was ever checked");
            errors++;
        end
        finish_run();
    end

endmodule

/* bench/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic emu_clk,
    output logic emu_rst
);

    initial begin
        emu_clk = 1'b0;
        forever #4 emu_clk = ~emu_clk;   // 8 ns period
    end

    // reset spans the first 16 rising edges
    initial begin
        emu_rst = 1'b1;
        repeat (16) @(posedge emu_clk);
        #1 emu_rst = 1'b0;
    end

endmodule

/* design/adc_collector.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module adc_collector (
    input  logic                             emu_clk,
    input  logic                             emu_rst,
    chunk_if.slice                           ch,
    input  logic [`NUM_SLICES-1:0]           sign_i,
    input  logic [`NUM_SLICES*`MAG_WIDTH-1:0] mag_i,
    output logic [`NUM_SLICES-1:0]           adc_sign_o,
    output logic [`NUM_SLICES*`MAG_WIDTH-1:0] adc_mag_o,
    output logic                             adc_valid_o,
    output logic                             clk_adc_o
);

    localparam int PH_BITS  = $clog2(`NUM_CHUNKS + 2);
    // low for half the frame, starting at phase 2
    localparam int CLK_FALL = 2;
    localparam int CLK_RISE = CLK_FALL + (`NUM_CHUNKS + 2) / 2 - 1;

    logic [PH_BITS-1:0] ph_num;

    // rebuild the frame phase from the strobes
    always_comb begin
        if (ch.load) begin
            ph_num = PH_BITS'(`NUM_CHUNKS + 1);
        end else if (ch.save) begin
            ph_num = PH_BITS'(`NUM_CHUNKS);
        end else if (ch.accumulate) begin
            ph_num = PH_BITS'(ch.chunk_idx);
        end else begin
            ph_num = '0;
        end
    end

    assign clk_adc_o = !((ph_num >= PH_BITS'(CLK_FALL)) && (ph_num <= PH_BITS'(CLK_RISE)));

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_valid_o <= 1'b0;
        end else begin
            adc_valid_o <= ch.load;   // high in phase 0
        end
    end

    always_ff @(posedge emu_clk) begin
        if (ch.load) begin
            adc_sign_o <= sign_i;
            adc_mag_o  <= mag_i;
        end
    end

endmodule

/* design/chan_emu_top.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module chan_emu_top import emu_pkg::*; (
    input  logic                              emu_clk,
    input  logic                              emu_rst,
    input  logic                              run_i,
    input  logic [`RX_SYMS*`SYM_BITS-1:0]     rx_bits_i,
    input  logic [`PI_WIDTH-1:0]              pi_code_i,
    input  logic                              coef_we_i,
    input  logic [$clog2(`NUM_TAPS)-1:0]      coef_addr_i,
    input  coef_t                             coef_data_i,
    output logic                              rx_take_o,
    output logic [`NUM_SLICES-1:0]            adc_sign_o,
    output logic [`NUM_SLICES*`MAG_WIDTH-1:0] adc_mag_o,
    output logic                              adc_valid_o,
    output logic                              clk_adc_o
);

    logic [`NUM_SLICES-1:0]            sign_w;
    logic [`NUM_SLICES*`MAG_WIDTH-1:0] mag_w;

    chunk_if ch ();

    frame_sequencer u_seq (
        .emu_clk   (emu_clk),
        .emu_rst   (emu_rst),
        .run_i     (run_i),
        .rx_bits_i (rx_bits_i),
        .pi_code_i (pi_code_i),
        .rx_take_o (rx_take_o),
        .ch        (ch.seq)
    );

    // slice k sees the history shifted by k symbols
    for (genvar k = 0; k < `NUM_SLICES; k++) begin : g_slice
        tap_slice #(
            .SLICE_OFS (k)
        ) u_slice (
            .emu_clk     (emu_clk),
            .emu_rst     (emu_rst),
            .ch          (ch.slice),
            .coef_we_i   (coef_we_i),
            .coef_addr_i (coef_addr_i),
            .coef_data_i (coef_data_i),
            .run_i       (run_i),
            .sign_o      (sign_w[k]),
            .mag_o       (mag_w[k*`MAG_WIDTH +: `MAG_WIDTH])
        );
    end

    adc_collector u_coll (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .ch          (ch.slice),
        .sign_i      (sign_w),
        .mag_i       (mag_w),
        .adc_sign_o  (adc_sign_o),
        .adc_mag_o   (adc_mag_o),
        .adc_valid_o (adc_valid_o),
        .clk_adc_o   (clk_adc_o)
    );

endmodule

/* design/chunk_if.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

interface chunk_if import emu_pkg::*;;

    sym_t       window [`WIN_SYMS];   // history from chunk_idx*CHUNK_WIDTH upward
    chunk_idx_t chunk_idx;
    logic       first;                // phase 0, restart the sum
    logic       accumulate;           // chunk phases
    logic       save;                 // register saturated result
    logic       load;                 // history update, collector capture

    modport seq (
        output window, chunk_idx, first, accumulate, save, load
    );

    modport slice (
        input window, chunk_idx, first, accumulate, save, load
    );

endinterface

/* design/emu_params.svh */
`ifndef EMU_PARAMS_SVH
`define EMU_PARAMS_SVH

// slice array and convolution shape
`define NUM_SLICES  4
`define CHUNK_WIDTH 4
`define NUM_CHUNKS  4
`define NUM_TAPS    16    // CHUNK_WIDTH * NUM_CHUNKS
`define WIN_SYMS    7     // CHUNK_WIDTH + NUM_SLICES - 1

// symbol stream
`define SYM_BITS    2
`define HIST_SYMS   19    // taps plus one symbol per extra slice
`define RX_SYMS     5

// datapath widths
`define COEF_WIDTH  8
`define ACC_WIDTH   14
`define MAG_WIDTH   8
`define PI_WIDTH    7
`define PI_MAX      127

`endif

/* design/emu_pkg.sv */
`include "emu_params.svh"

package emu_pkg;

    typedef logic [`SYM_BITS-1:0] sym_t;                // one PAM4 symbol
    typedef logic signed [`COEF_WIDTH-1:0] coef_t;      // step response tap
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;
    typedef logic [$clog2(`NUM_CHUNKS)-1:0] chunk_idx_t;

    typedef enum logic [1:0] {
        SLIP_NONE,
        SLIP_EARLY,   // PI wrapped PI_MAX -> 0, take one extra symbol
        SLIP_LATE     // PI wrapped 0 -> PI_MAX, take one symbol less
    } slip_e;

    typedef enum logic [1:0] {PH_CHUNK, PH_SAVE, PH_LOAD} phase_e;

    // PAM4 level: 00 -> -3, 01 -> -1, 10 -> +1, 11 -> +3
    function automatic logic signed [3:0] sym_level(sym_t s);
        return $signed({1'b0, s, 1'b1}) - 4'sd4;
    endfunction

endpackage

/* design/frame_sequencer.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module frame_sequencer import emu_pkg::*; (
    input  logic                          emu_clk,
    input  logic                          emu_rst,
    input  logic                          run_i,
    input  logic [`RX_SYMS*`SYM_BITS-1:0] rx_bits_i,
    input  logic [`PI_WIDTH-1:0]          pi_code_i,
    output logic                          rx_take_o,
    chunk_if.seq                          ch
);

    localparam int PH_BITS = $clog2(`NUM_CHUNKS + 2);
    localparam int LAST_PH = `NUM_CHUNKS + 1;

    logic [PH_BITS-1:0]   ph_cnt;
    phase_e               phase;
    chunk_idx_t           chunk_sel;
    sym_t                 hist     [`HIST_SYMS];
    sym_t                 hist_nxt [`HIST_SYMS];
    sym_t                 rx_sym   [`RX_SYMS];
    logic [`PI_WIDTH-1:0] pi_last;
    slip_e                slip_q;
    slip_e                slip_d;
    logic                 early_w;
    logic                 late_w;
    int                   n_new;

    // frame phase counter, parked at 0 while stopped
    always_ff @(posedge emu_clk) begin
        if (emu_rst || !run_i) begin
            ph_cnt <= '0;
        end else if (ph_cnt == PH_BITS'(LAST_PH)) begin
            ph_cnt <= '0;
        end else begin
            ph_cnt <= ph_cnt + 1'b1;
        end
    end

    always_comb begin
        if (ph_cnt < PH_BITS'(`NUM_CHUNKS)) begin
            phase = PH_CHUNK;
        end else if (ph_cnt == PH_BITS'(`NUM_CHUNKS)) begin
            phase = PH_SAVE;
        end else begin
            phase = PH_LOAD;
        end
    end

    assign chunk_sel     = (phase == PH_CHUNK) ? chunk_idx_t'(ph_cnt) : '0;
    assign ch.chunk_idx  = chunk_sel;
    assign ch.first      = (ph_cnt == '0);
    assign ch.accumulate = (phase == PH_CHUNK);
    assign ch.save       = (phase == PH_SAVE) && run_i;
    assign ch.load       = (phase == PH_LOAD) && run_i;
    assign rx_take_o     = ch.load;

    // wrap check against the code seen at the previous load
    assign early_w = (pi_last == `PI_MAX) && (pi_code_i == '0);
    assign late_w  = (pi_last == '0) && (pi_code_i == `PI_MAX);

    always_comb begin
        if (early_w) begin
            slip_d = SLIP_EARLY;
        end else if (late_w) begin
            slip_d = SLIP_LATE;
        end else begin
            slip_d = SLIP_NONE;
        end
    end

    always_comb begin
        for (int s = 0; s < `RX_SYMS; s++) begin
            rx_sym[s] = rx_bits_i[s*`SYM_BITS +: `SYM_BITS];
        end
    end

    // shift out the oldest symbols, rx symbol 0 lands just above the kept ones
    always_comb begin
        case (slip_q)
            SLIP_EARLY: n_new = `CHUNK_WIDTH + 1;
            SLIP_LATE:  n_new = `CHUNK_WIDTH - 1;
            default:    n_new = `CHUNK_WIDTH;
        endcase
        for (int i = 0; i < `HIST_SYMS; i++) begin
            if (i < `HIST_SYMS - n_new) begin
                hist_nxt[i] = hist[i + n_new];
            end else begin
                hist_nxt[i] = rx_sym[i - (`HIST_SYMS - n_new)];
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int i = 0; i < `HIST_SYMS; i++) begin
                hist[i] <= '0;
            end
            pi_last <= '0;
            slip_q  <= SLIP_NONE;
        end else if (ch.load) begin
            hist    <= hist_nxt;
            pi_last <= pi_code_i;
            slip_q  <= slip_d;   // applied at the next load
        end
    end

    always_comb begin
        for (int i = 0; i < `WIN_SYMS; i++) begin
            ch.window[i] = hist[chunk_sel*`CHUNK_WIDTH + i];
        end
    end

    // a pending slip never meets the opposite wrap
    a_slip_conflict: assert property (@(posedge emu_clk) disable iff (emu_rst)
        ch.load |-> !(slip_q == SLIP_EARLY && late_w) && !(slip_q == SLIP_LATE && early_w));

endmodule

/* design/tap_slice.sv */
`timescale 1ns/1ps
`include "emu_params.svh"

module tap_slice import emu_pkg::*; #(
    parameter int SLICE_OFS = 0
) (
    input  logic                         emu_clk,
    input  logic                         emu_rst,
    chunk_if.slice                       ch,
    input  logic                         coef_we_i,
    input  logic [$clog2(`NUM_TAPS)-1:0] coef_addr_i,
    input  coef_t                        coef_data_i,
    input  logic                         run_i,
    output logic                         sign_o,
    output logic [`MAG_WIDTH-1:0]        mag_o
);

    localparam int MAG_CAP = (1 << `MAG_WIDTH) - 1;

    coef_t                  tab [`NUM_TAPS];
    acc_t                   chunk_sum;
    acc_t                   acc;
    logic [`ACC_WIDTH-1:0]  acc_abs;

    // step response table, written only while the emulator is stopped
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int t = 0; t < `NUM_TAPS; t++) begin
                tab[t] <= '0;
            end
        end else if (coef_we_i && !run_i) begin
            tab[coef_addr_i] <= coef_data_i;
        end
    end

    // one chunk of taps against the window seen from this slice's offset
    always_comb begin
        chunk_sum = '0;
        for (int s = 0; s < `CHUNK_WIDTH; s++) begin
            chunk_sum = chunk_sum
                      + acc_t'(tab[ch.chunk_idx*`CHUNK_WIDTH + s])
                      * acc_t'(sym_level(ch.window[SLICE_OFS + s]));
        end
    end

    always_ff @(posedge emu_clk) begin
        if (ch.accumulate) begin
            acc <= (ch.first ? acc_t'(0) : acc) + chunk_sum;
        end
    end

    assign acc_abs = acc[`ACC_WIDTH-1] ? -acc : acc;

    // sign is 1 for a sum of zero or more
    always_ff @(posedge emu_clk) begin
        if (ch.save) begin
            sign_o <= !acc[`ACC_WIDTH-1];
            mag_o  <= (acc_abs > MAG_CAP) ? '1 : acc_abs[`MAG_WIDTH-1:0];
        end
    end

    a_coef_idle: assert property (@(posedge emu_clk) disable iff (emu_rst)
        coef_we_i |-> !run_i);

endmodule

/* sources.f */
+incdir+design
design/emu_pkg.sv
design/chunk_if.sv
design/frame_sequencer.sv
design/tap_slice.sv
design/adc_collector.sv
design/chan_emu_top.sv
bench/tb_clkgen.sv
bench/chan_emu_tb.sv
